/* logic/cache_params.svh */
// cache geometry and datapath widths for the direct-mapped data cache
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ------------------------------------------------------------
// geometry
`define CACHE_LINES     8
`define WORDS_PER_LINE  4

// ------------------------------------------------------------
// widths
`define WORD_W          32
`define ADDR_W          30      // processor word address
`define INDEX_W         3       // log2 of CACHE_LINES
`define OFFSET_W        2       // log2 of WORDS_PER_LINE
`define TAG_W           25      // ADDR_W - INDEX_W - OFFSET_W
`define LINE_W          128     // WORD_W * WORDS_PER_LINE
`define LINE_ADDR_W     28      // ADDR_W - OFFSET_W

`endif

/* logic/cache_pkg.sv */
// shared types of the data cache: vector widths, request structs, miss states
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

	typedef logic [`WORD_W-1:0]      word_t;
	typedef logic [`ADDR_W-1:0]      word_addr_t;
	typedef logic [`LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [`LINE_W-1:0]      line_t;      // word 0 in the low bits
	typedef logic [`INDEX_W-1:0]     index_t;
	typedef logic [`OFFSET_W-1:0]    offset_t;
	typedef logic [`TAG_W-1:0]       tag_t;

	// processor side, held while stall is high
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} cpu_req_t;

	// memory side, held until mem_ready
	typedef struct packed {
		logic       read;
		logic       write;
		line_addr_t addr;
		line_t      wdata;
	} mem_req_t;

	typedef enum logic [1:0] {st_ready, st_write_back, st_refill} miss_state_t;

endpackage

`default_nettype wire

/* logic/tag_store.sv */
// tag store: per-line valid bit and tag, hit compare and victim lookup
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module tag_store (
	input  logic            clk,
	input  logic            rst_n,
	input  cache_pkg::index_t index,
	input  cache_pkg::tag_t   tag,
	input  logic            fill,
	output logic            hit,
	output logic            victim_valid,
	output cache_pkg::tag_t   victim_tag
);

	import cache_pkg::*;

	// ------------------------------------------------------------
	// storage
	logic [`CACHE_LINES-1:0] valid_q;
	tag_t                    tag_q [`CACHE_LINES];

	// valid bits are the only control state here
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (fill) begin
			valid_q[index] <= 1'b1;
		end
	end

	// tag follows the refilled line
	always_ff @(posedge clk) begin
		if (fill) begin
			tag_q[index] <= tag;
		end
	end

	// ------------------------------------------------------------
	// lookup
	always_comb begin
		victim_valid = valid_q[index];
		victim_tag   = tag_q[index];  // line that a miss would evict
		hit          = victim_valid && (victim_tag == tag);
	end

	// a hit and a valid victim are the same entry seen two ways:
	// on a miss with a valid entry the stored tag names the
	// line that has to go back to memory first

endmodule

`default_nettype wire

/* logic/line_store.sv */
// line store: data array with word writes, line fills and combinational reads
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module line_store (
	input  logic               clk,
	input  cache_pkg::index_t  index,
	input  cache_pkg::offset_t offset,
	input  logic               word_wr,
	input  cache_pkg::word_t   wdata,
	input  logic               fill,
	input  cache_pkg::line_t   fill_line,
	output cache_pkg::word_t   rd_word,
	output cache_pkg::line_t   rd_line
);

	import cache_pkg::*;

	// ------------------------------------------------------------
	// data array, one word per entry
	word_t data_q [`CACHE_LINES][`WORDS_PER_LINE];

	always_ff @(posedge clk) begin
		if (fill) begin
			// whole line from memory, word 0 in the low bits
			for (int w = 0; w < `WORDS_PER_LINE; w++) begin
				data_q[index][w] <= fill_line[w*`WORD_W +: `WORD_W];
			end
		end else if (word_wr) begin
			data_q[index][offset] <= wdata;  // write hit
		end
	end

	// ------------------------------------------------------------
	// reads

	// addressed word for the processor
	always_comb begin
		rd_word = data_q[index][offset];
	end

	// indexed line for the write-back
	always_comb begin
		rd_line = '0;
		for (int w = 0; w < `WORDS_PER_LINE; w++) begin
			rd_line[w*`WORD_W +: `WORD_W] = data_q[index][w];
		end
	end

	// fill and word_wr never coincide in practice:
	// word_wr only comes in st_ready, fill only in st_refill.
	// fill is checked first anyway so a line load can never
	// be torn by a stray word write

	// no read-during-write forwarding is needed here since a
	// processor access completes in the same cycle it is
	// presented with stall low, and the refilled word is read
	// from the array in the cycle after the fill edge

endmodule

`default_nettype wire

/* logic/miss_fsm.sv */
// miss state machine: serves hits, writes back the victim and refills the line
`timescale 1ns/10ps
`default_nettype none

module miss_fsm (
	input  logic                clk,
	input  logic                rst_n,
	input  cache_pkg::cpu_req_t req,
	input  cache_pkg::index_t   index,
	input  cache_pkg::tag_t     tag,
	input  logic                hit,
	input  logic                victim_valid,
	input  cache_pkg::tag_t     victim_tag,
	input  cache_pkg::line_t    victim_line,
	input  logic                mem_ready,
	output cache_pkg::mem_req_t mem_req,
	output logic                word_wr,
	output logic                fill,
	output logic                stall
);

	import cache_pkg::*;

	miss_state_t state_q;
	miss_state_t state_d;
	logic        access;   // read or write pending
	logic        served;   // hit while idle

	always_comb begin
		access = req.read | req.write;
		served = (state_q == st_ready) && hit;
	end

	// ------------------------------------------------------------
	// next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			st_ready: begin
				if (access && !hit) begin
					// a clean slot skips straight to the refill
					state_d = victim_valid ? st_write_back : st_refill;
				end
			end
			st_write_back: begin
				if (mem_ready) begin
					state_d = st_refill;
				end
			end
			st_refill: begin
				if (mem_ready) begin
					state_d = st_ready;
				end
			end
			default: state_d = st_ready;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= st_ready;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------
	// memory request, a function of state only so it holds
	// steady for as long as mem_ready stays low
	always_comb begin
		mem_req = '0;
		case (state_q)
			st_write_back: begin
				mem_req.write = 1'b1;
				mem_req.addr  = {victim_tag, index};  // victim line address
				mem_req.wdata = victim_line;
			end
			st_refill: begin
				mem_req.read = 1'b1;
				mem_req.addr = {tag, index};          // requested line
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// array control and processor stall
	always_comb begin
		fill    = (state_q == st_refill) && mem_ready;
		word_wr = served && req.write;
		stall   = access && !served;  // low on a hit in the request's first cycle
	end

	// after the refill edge the state is back in st_ready and the
	// new tag makes the held request hit, so stall falls then

endmodule

`default_nettype wire

/* logic/data_cache.sv */
// direct-mapped write-back data cache between a word port and a line memory
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module data_cache (
	input  logic                clk,
	input  logic                rst_n,
	// processor side
	input  cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::word_t    rdata,
	output logic                stall,
	// memory side
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::line_t    mem_rdata,
	input  logic                mem_ready
);

	import cache_pkg::*;

	// ------------------------------------------------------------
	// address split
	index_t  index;
	offset_t offset;
	tag_t    tag;

	assign offset = cpu_req.addr[`OFFSET_W-1:0];
	assign index  = cpu_req.addr[`OFFSET_W +: `INDEX_W];
	assign tag    = cpu_req.addr[`ADDR_W-1 -: `TAG_W];

	// ------------------------------------------------------------
	// internal nets
	logic  hit;
	logic  victim_valid;
	tag_t  victim_tag;
	line_t rd_line;
	logic  word_wr;
	logic  fill;

	tag_store i_tag_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.index        (index),
		.tag          (tag),
		.fill         (fill),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag)
	);

	line_store i_line_store (
		.clk       (clk),
		.index     (index),
		.offset    (offset),
		.word_wr   (word_wr),
		.wdata     (cpu_req.wdata),
		.fill      (fill),
		.fill_line (mem_rdata),   // refill data straight from memory
		.rd_word   (rdata),
		.rd_line   (rd_line)
	);

	miss_fsm i_miss_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (cpu_req),
		.index        (index),
		.tag          (tag),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag),
		.victim_line  (rd_line),
		.mem_ready    (mem_ready),
		.mem_req      (mem_req),
		.word_wr      (word_wr),
		.fill         (fill),
		.stall        (stall)
	);

endmodule

`default_nettype wire

/* sim/slow_mem.sv */
// backing memory for the cache testbench: line reads and writes after a random delay
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module slow_mem (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cache_pkg::mem_req_t   mem_req,
	output cache_pkg::line_t      mem_rdata,
	output logic                  mem_ready,
	// one pulse per accepted write-back
	output logic                  wb_done,
	output cache_pkg::line_addr_t wb_addr,
	output cache_pkg::line_t      wb_line
);

	import cache_pkg::*;

	localparam int MEM_LINE_BITS = 6;   // 64 lines
	localparam int MEM_WORDS     = (1 << MEM_LINE_BITS) * `WORDS_PER_LINE;

	word_t      mem [MEM_WORDS];
	integer     seed = 32;
	logic       busy;       // request seen, delay drawn
	logic [1:0] wait_cnt;

	// ------------------------------------------------------------
	// request handling, mem_ready high for exactly one cycle
	always @(posedge clk or negedge rst_n) begin
		logic [31:0] rnd;
		logic [7:0]  wa;
		if (!rst_n) begin
			// each word holds its own address xor a fixed pattern
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= word_t'(i) ^ 32'hA5A5_0000;
			end
			mem_ready <= 1'b0;
			mem_rdata <= '0;
			busy      <= 1'b0;
			wait_cnt  <= '0;
			wb_done   <= 1'b0;
			wb_addr   <= '0;
			wb_line   <= '0;
		end else begin
			wb_done <= 1'b0;
			if (mem_ready) begin
				// the request completes at this edge
				mem_ready <= 1'b0;
				busy      <= 1'b0;
				if (mem_req.write) begin
					for (int w = 0; w < `WORDS_PER_LINE; w++) begin
						wa = {mem_req.addr[MEM_LINE_BITS-1:0], 2'(w)};
						mem[wa] <= mem_req.wdata[w*`WORD_W +: `WORD_W];
					end
					wb_done <= 1'b1;
					wb_addr <= mem_req.addr;
					wb_line <= mem_req.wdata;
				end
			end else if (mem_req.read || mem_req.write) begin
				if (!busy) begin
					rnd      = $random(seed);
					wait_cnt <= rnd[1:0];   // 0 to 3 extra idle cycles
					busy     <= 1'b1;
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					mem_ready <= 1'b1;
					for (int w = 0; w < `WORDS_PER_LINE; w++) begin
						wa = {mem_req.addr[MEM_LINE_BITS-1:0], 2'(w)};
						mem_rdata[w*`WORD_W +: `WORD_W] <= mem[wa];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_data_cache.sv */
// testbench for the data cache with random word traffic checked against a flat memory model
`timescale 1ns/10ps
`default_nettype none

`include "cache_params.svh"

module tb_data_cache;

	import cache_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_ACCESS   = 400;
	localparam int WINDOW_WORDS = 256;
	localparam int ACCESS_BOUND = 20;   // cycles for a worst miss with both transfers
	localparam int TIMEOUT_NS   = (NUM_ACCESS + WINDOW_WORDS) * ACCESS_BOUND * CLK_PERIOD;

	logic       clk;
	logic       rst_n;
	cpu_req_t   cpu_req;
	word_t      rdata;
	logic       stall;
	mem_req_t   mem_req;
	line_t      mem_rdata;
	logic       mem_ready;
	logic       wb_done;
	line_addr_t wb_addr;
	line_t      wb_line;

	// ------------------------------------------------------------
	// reference model
	word_t  model [WINDOW_WORDS];
	logic   line_valid [`CACHE_LINES];
	tag_t   line_tag [`CACHE_LINES];
	line_t  wb_expect;
	integer seed = 32;
	logic   missed;          // last access stalled in its first cycle
	int     wb_expected;

	int val_checks;
	int val_errors;
	int line_checks;
	int line_errors;
	int test_checks;         // snapshot at the start of a test
	int test_errors;

	data_cache i_data_cache (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_req   (cpu_req),
		.rdata     (rdata),
		.stall     (stall),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	slow_mem i_slow_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready),
		.wb_done   (wb_done),
		.wb_addr   (wb_addr),
		.wb_line   (wb_line)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the cache did not finish the accesses in %0d ns", TIMEOUT_NS);
		$display("Checks failed");
		$finish;
	end

	// ------------------------------------------------------------
	// compare tasks
	task automatic check_word(input string name, input word_t exp, input word_t act);
		val_checks++;
		if (act !== exp) begin
			val_errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		line_checks++;
		if (act !== exp) begin
			line_errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		val_checks++;
		if (act !== exp) begin
			val_errors++;
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d checks, %0d errors", name,
			val_checks - test_checks, val_errors - test_errors);
		test_checks = val_checks;
		test_errors = val_errors;
	endtask

	// one processor access, held until stall is low
	task automatic run_access(input logic is_write, input word_addr_t addr,
		input word_t wdata, input string name);
		cpu_req_t req;
		index_t   idx;
		tag_t     tg;
		logic     exp_stall;
		idx       = addr[`OFFSET_W +: `INDEX_W];
		tg        = addr[`ADDR_W-1 -: `TAG_W];
		exp_stall = !(line_valid[idx] && (line_tag[idx] == tg));
		if (exp_stall && line_valid[idx]) begin
			wb_expected++;   // valid victim goes back first
		end
		req.read  = !is_write;
		req.write = is_write;
		req.addr  = addr;
		req.wdata = is_write ? wdata : '0;
		@(posedge clk);
		cpu_req <= req;
		@(negedge clk);
		check_flag($sformatf("%s first-cycle stall", name), exp_stall, stall);
		while (stall) begin
			@(negedge clk);
		end
		if (is_write) begin
			model[addr[7:0]] = wdata;
		end else begin
			check_word($sformatf("%s read %h", name, addr), model[addr[7:0]], rdata);
		end
		line_valid[idx] = 1'b1;
		line_tag[idx]   = tg;
		missed          = exp_stall;
	endtask

	// write-back lines must carry the model's newest words
	always @(negedge clk) begin
		if (wb_done) begin
			for (int w = 0; w < `WORDS_PER_LINE; w++) begin
				wb_expect[w*`WORD_W +: `WORD_W] = model[{wb_addr[5:0], 2'(w)}];
			end
			check_line($sformatf("write-back line %h", wb_addr), wb_expect, wb_line);
		end
	end

	// ------------------------------------------------------------
	// stimulus
	initial begin
		logic [31:0] rnd;
		word_addr_t  addr;
		word_t       wdata;
		rst_n   <= 1'b0;
		cpu_req <= '0;
		for (int i = 0; i < WINDOW_WORDS; i++) begin
			model[i] = word_t'(i) ^ 32'hA5A5_0000;
		end
		for (int i = 0; i < `CACHE_LINES; i++) begin
			line_valid[i] = 1'b0;
			line_tag[i]   = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_flag("reset mem read", 1'b0, mem_req.read);
		check_flag("reset mem write", 1'b0, mem_req.write);
		check_flag("reset idle stall", 1'b0, stall);
		report_test("reset");

		for (int i = 0; i < NUM_ACCESS; i++) begin
			rnd   = $random(seed);
			addr  = word_addr_t'(rnd[7:0]);
			wdata = $random(seed);
			run_access(rnd[8], addr, wdata, $sformatf("access %0d", i));
			if (missed) begin
				// same line again, now resident
				rnd  = $random(seed);
				addr = {addr[`ADDR_W-1:`OFFSET_W], rnd[1:0]};
				run_access(1'b0, addr, '0, $sformatf("refill hit %0d", i));
			end
		end
		report_test("random_access");

		for (int a = 0; a < WINDOW_WORDS; a++) begin
			run_access(1'b0, word_addr_t'(a), '0, $sformatf("sweep %0d", a));
		end
		report_test("read_sweep");

		@(posedge clk);
		cpu_req <= '0;
		repeat (2) @(negedge clk);
		check_flag("write-back count", 1'b1, line_checks == wb_expected);
		$display("test write_back: %0d lines, %0d errors, %0d expected", line_checks,
			line_errors, wb_expected);

		$display("checks %0d, errors %0d", val_checks + line_checks, val_errors + line_errors);
		if (val_errors + line_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/cache_pkg.sv
logic/tag_store.sv
logic/line_store.sv
logic/miss_fsm.sv
logic/data_cache.sv
sim/slow_mem.sv
sim/tb_data_cache.sv

/* run.sh */
#!/usr/bin/env bash
# build the data cache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps -f src.f \
	--top-module tb_data_cache -o tb_data_cache > build.log 2>&1 \
	&& ./obj_dir/tb_data_cache > "$LOG" 2>&1 \
	|| { echo "build or simulation error, see build.log and $LOG"; exit 1; }

grep -q "Checks failed" "$LOG" \
	&& { echo "simulation reported failures, see $LOG"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
